/* design/risky_macros.svh */
`ifndef RISKY_MACROS_SVH
`define RISKY_MACROS_SVH

// Core sizing
`define RISKY_XLEN      32
`define RISKY_NREGS     32
`define RISKY_RESET_PC  32'h0000_0000

// Major opcodes
`define RISKY_OP_LUI    7'b0110111
`define RISKY_OP_AUIPC  7'b0010111
`define RISKY_OP_JAL    7'b1101111
`define RISKY_OP_JALR   7'b1100111
`define RISKY_OP_BRANCH 7'b1100011
`define RISKY_OP_LOAD   7'b0000011
`define RISKY_OP_STORE  7'b0100011
`define RISKY_OP_OP_IMM 7'b0010011
`define RISKY_OP_OP     7'b0110011

// ALU funct3
`define RISKY_F3_ADD    3'b000 // ADD/SUB
`define RISKY_F3_SLL    3'b001
`define RISKY_F3_SLT    3'b010
`define RISKY_F3_SLTU   3'b011
`define RISKY_F3_XOR    3'b100
`define RISKY_F3_SR     3'b101 // SRL/SRA
`define RISKY_F3_OR     3'b110
`define RISKY_F3_AND    3'b111

// Branch funct3
`define RISKY_F3_BEQ    3'b000
`define RISKY_F3_BNE    3'b001
`define RISKY_F3_BLT    3'b100
`define RISKY_F3_BGE    3'b101
`define RISKY_F3_BLTU   3'b110
`define RISKY_F3_BGEU   3'b111

`define RISKY_F7_ALT    7'b0100000 // SUB and SRA

`endif

/* design/risky_pkg.sv */
`default_nettype none

`include "risky_macros.svh"

package risky_pkg;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    // Also carries the B layout
    typedef struct packed {
        logic [6:0] imm_hi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        logic [6:0] opcode;
    } s_fmt_t;

    typedef struct packed {
        logic [19:0] imm; // U immediate, or scrambled J immediate
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } u_fmt_t;

    typedef union packed {
        r_fmt_t      r_fmt;
        i_fmt_t      i_fmt;
        s_fmt_t      s_fmt;
        u_fmt_t      u_fmt;
        logic [31:0] raw;
    } inst_t;

    typedef enum logic [1:0] {PC_HOLD, PC_PLUS4, PC_ALU, PC_BRANCH} pc_sel_e;
    typedef enum logic [1:0] {A_RS1, A_PC, A_ZERO} a_sel_e;
    typedef enum logic [1:0] {B_RS2, B_IMM} b_sel_e;
    typedef enum logic [1:0] {ALU_ADD, ALU_FUNC, ALU_CMP} alu_mode_e;
    typedef enum logic [1:0] {WB_ALU, WB_PC4, WB_MEM} wb_sel_e;

    typedef struct packed {
        logic      ir_load;
        pc_sel_e   pc_sel;
        a_sel_e    a_sel;
        b_sel_e    b_sel;
        alu_mode_e alu_mode;
        logic      rf_we;
        wb_sel_e   wb_sel;
        logic      addr_load;
        logic      mem_rd;
        logic      mem_wr;
        logic      mem_from_addr; // Address register drives the bus
    } uop_t;

    typedef struct packed {
        logic [`RISKY_XLEN-1:0] addr;
        logic [`RISKY_XLEN-1:0] wdata;
        logic                   rd_en;
        logic                   wr_en;
    } mem_req_t;

endpackage

`default_nettype wire

/* design/risky_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

`include "risky_macros.svh"

module risky_ctrl
    import risky_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic [6:0] opcode,
    output uop_t       uop,
    output logic       halted
);

    typedef enum logic [1:0] {S_FETCH, S_EXEC, S_MEM, S_HALT} state_e;

    state_e state, state_nxt;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= S_FETCH;
        end else begin
            state <= state_nxt;
        end
    end

    assign halted = (state == S_HALT);

    always_comb begin
        uop       = '0; // Everything idle, PC held
        state_nxt = state;
        case (state)
            S_FETCH: begin
                uop.ir_load = 1'b1;
                uop.mem_rd  = 1'b1;
                state_nxt   = S_EXEC;
            end
            S_EXEC: begin
                state_nxt = S_FETCH;
                case (opcode)
                    `RISKY_OP_LUI, `RISKY_OP_AUIPC: begin
                        uop.a_sel  = (opcode == `RISKY_OP_LUI) ? A_ZERO : A_PC;
                        uop.b_sel  = B_IMM;
                        uop.rf_we  = 1'b1;
                        uop.pc_sel = PC_PLUS4;
                    end
                    `RISKY_OP_JAL, `RISKY_OP_JALR: begin
                        uop.a_sel  = (opcode == `RISKY_OP_JAL) ? A_PC : A_RS1;
                        uop.b_sel  = B_IMM;
                        uop.rf_we  = 1'b1;
                        uop.wb_sel = WB_PC4; // Link address
                        uop.pc_sel = PC_ALU;
                    end
                    `RISKY_OP_BRANCH: begin
                        uop.alu_mode = ALU_CMP;
                        uop.pc_sel   = PC_BRANCH; // Datapath picks target
                    end
                    `RISKY_OP_OP, `RISKY_OP_OP_IMM: begin
                        uop.b_sel    = (opcode == `RISKY_OP_OP) ? B_RS2 : B_IMM;
                        uop.alu_mode = ALU_FUNC;
                        uop.rf_we    = 1'b1;
                        uop.pc_sel   = PC_PLUS4;
                    end
                    `RISKY_OP_LOAD, `RISKY_OP_STORE: begin
                        // Effective address rs1 + imm
                        uop.b_sel     = B_IMM;
                        uop.addr_load = 1'b1;
                        state_nxt     = S_MEM;
                    end
                    default: state_nxt = S_HALT; // Undefined opcode
                endcase
            end
            S_MEM: begin
                uop.mem_from_addr = 1'b1;
                uop.pc_sel        = PC_PLUS4;
                state_nxt         = S_FETCH;
                if (opcode == `RISKY_OP_LOAD) begin
                    uop.mem_rd = 1'b1;
                    uop.rf_we  = 1'b1;
                    uop.wb_sel = WB_MEM;
                end else begin
                    uop.mem_wr = 1'b1;
                end
            end
            default: state_nxt = S_HALT; // Only reset leaves HALT
        endcase
    end

    // Memory port never sees both strobes
    assert property (@(posedge clk) disable iff (!rst_n) !(uop.mem_rd && uop.mem_wr))
        else $error("ctrl: read and write strobes together");

    // Halt is sticky and silent
    assert property (@(posedge clk) disable iff (!rst_n)
        halted |=> halted && !uop.mem_rd && !uop.mem_wr && !uop.rf_we)
        else $error("ctrl: activity after halt");

endmodule

`default_nettype wire

/* design/risky_regfile.sv */
`timescale 1ns/1ps
`default_nettype none

`include "risky_macros.svh"

module risky_regfile (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic [4:0]             rs1_idx,
    input  logic [4:0]             rs2_idx,
    input  logic [4:0]             rd_idx,
    input  logic [`RISKY_XLEN-1:0] rd_data,
    input  logic                   we,
    output logic [`RISKY_XLEN-1:0] rs1_data,
    output logic [`RISKY_XLEN-1:0] rs2_data
);

    logic [`RISKY_XLEN-1:0] regs [`RISKY_NREGS];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `RISKY_NREGS; i++) regs[i] <= '0;
        end else if (we && rd_idx != 5'd0) begin // x0 is never written
            regs[rd_idx] <= rd_data;
        end
    end

    assign rs1_data = regs[rs1_idx];
    assign rs2_data = regs[rs2_idx];

    assert property (@(posedge clk) disable iff (!rst_n)
        (rs1_idx == 5'd0) |-> (rs1_data == '0))
        else $error("regfile: x0 reads nonzero");

endmodule

`default_nettype wire

/* design/risky_imm.sv */
`timescale 1ns/1ps
`default_nettype none

`include "risky_macros.svh"

module risky_imm
    import risky_pkg::*;
(
    input  inst_t                  inst,
    output logic [`RISKY_XLEN-1:0] imm
);

    always_comb begin
        case (inst.r_fmt.opcode)
            `RISKY_OP_OP_IMM, `RISKY_OP_LOAD, `RISKY_OP_JALR:
                imm = {{(`RISKY_XLEN-12){inst.i_fmt.imm[11]}}, inst.i_fmt.imm};
            `RISKY_OP_STORE:
                imm = {{(`RISKY_XLEN-12){inst.s_fmt.imm_hi[6]}},
                       inst.s_fmt.imm_hi, inst.s_fmt.imm_lo};
            `RISKY_OP_BRANCH: // imm[12|10:5] in hi, imm[4:1|11] in lo
                imm = {{(`RISKY_XLEN-12){inst.s_fmt.imm_hi[6]}}, inst.s_fmt.imm_lo[0],
                       inst.s_fmt.imm_hi[5:0], inst.s_fmt.imm_lo[4:1], 1'b0};
            `RISKY_OP_LUI, `RISKY_OP_AUIPC:
                imm = {inst.u_fmt.imm, 12'd0};
            `RISKY_OP_JAL: // Bits are stored as imm[20|10:1|11|19:12]
                imm = {{(`RISKY_XLEN-20){inst.u_fmt.imm[19]}}, inst.u_fmt.imm[7:0],
                       inst.u_fmt.imm[8], inst.u_fmt.imm[18:9], 1'b0};
            default: imm = '0;
        endcase
    end

endmodule

`default_nettype wire

/* design/risky_alu.sv */
`timescale 1ns/1ps
`default_nettype none

`include "risky_macros.svh"

module risky_alu
    import risky_pkg::*;
(
    input  alu_mode_e              mode,
    input  logic [2:0]             funct3,
    input  logic                   alt,
    input  logic [`RISKY_XLEN-1:0] a,
    input  logic [`RISKY_XLEN-1:0] b,
    output logic [`RISKY_XLEN-1:0] result,
    output logic                   taken
);

    logic [4:0] shamt;
    logic       lt_s;
    logic       lt_u;

    assign shamt = b[4:0]; // Shift amounts masked to five bits
    assign lt_s  = $signed(a) < $signed(b);
    assign lt_u  = a < b;

    always_comb begin
        result = a + b;
        taken  = 1'b0;
        case (mode)
            ALU_FUNC: begin
                case (funct3)
                    `RISKY_F3_ADD:  result = alt ? a - b : a + b;
                    `RISKY_F3_SLL:  result = a << shamt;
                    `RISKY_F3_SLT:  result = {{(`RISKY_XLEN-1){1'b0}}, lt_s};
                    `RISKY_F3_SLTU: result = {{(`RISKY_XLEN-1){1'b0}}, lt_u};
                    `RISKY_F3_XOR:  result = a ^ b;
                    `RISKY_F3_SR: begin
                        if (alt) result = $signed(a) >>> shamt; // Sign fill
                        else     result = a >> shamt;
                    end
                    `RISKY_F3_OR:   result = a | b;
                    default:        result = a & b; // AND
                endcase
            end
            ALU_CMP: begin
                case (funct3)
                    `RISKY_F3_BEQ:  taken = (a == b);
                    `RISKY_F3_BNE:  taken = (a != b);
                    `RISKY_F3_BLT:  taken = lt_s;
                    `RISKY_F3_BGE:  taken = !lt_s;
                    `RISKY_F3_BLTU: taken = lt_u;
                    `RISKY_F3_BGEU: taken = !lt_u;
                    default:        taken = 1'b0;
                endcase
            end
            default: result = a + b; // Address and upper-immediate sums
        endcase
    end

endmodule

`default_nettype wire

/* design/risky_datapath.sv */
`timescale 1ns/1ps
`default_nettype none

`include "risky_macros.svh"

module risky_datapath
    import risky_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst_n,
    input  uop_t                   uop,
    input  logic [`RISKY_XLEN-1:0] mem_rdata,
    output mem_req_t               mem_req,
    output logic [6:0]             opcode
);

    logic [`RISKY_XLEN-1:0] pc;
    logic [`RISKY_XLEN-1:0] addr_q;
    inst_t                  ir;

    logic [`RISKY_XLEN-1:0] rs1_data, rs2_data, imm;
    logic [`RISKY_XLEN-1:0] op_a, op_b, alu_result, wb_data;
    logic [`RISKY_XLEN-1:0] pc_plus4, br_target, pc_next;
    logic                   taken;
    logic                   alt;

    risky_regfile u_regfile (
        .clk      (clk),
        .rst_n    (rst_n),
        .rs1_idx  (ir.r_fmt.rs1),
        .rs2_idx  (ir.r_fmt.rs2),
        .rd_idx   (ir.r_fmt.rd),
        .rd_data  (wb_data),
        .we       (uop.rf_we),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data)
    );

    risky_imm u_imm (
        .inst (ir),
        .imm  (imm)
    );

    // funct7 only counts for register ops and immediate shifts
    assign alt = (ir.r_fmt.funct7 == `RISKY_F7_ALT) &&
                 (uop.b_sel == B_RS2 || ir.r_fmt.funct3 == `RISKY_F3_SR);

    risky_alu u_alu (
        .mode   (uop.alu_mode),
        .funct3 (ir.r_fmt.funct3),
        .alt    (alt),
        .a      (op_a),
        .b      (op_b),
        .result (alu_result),
        .taken  (taken)
    );

    always_comb begin
        case (uop.a_sel)
            A_PC:    op_a = pc;
            A_ZERO:  op_a = '0;
            default: op_a = rs1_data;
        endcase
        op_b = (uop.b_sel == B_IMM) ? imm : rs2_data;
        case (uop.wb_sel)
            WB_PC4:  wb_data = pc_plus4;
            WB_MEM:  wb_data = mem_rdata;
            default: wb_data = alu_result;
        endcase
    end

    assign pc_plus4  = pc + 4;
    assign br_target = pc + imm;

    always_comb begin
        case (uop.pc_sel)
            PC_PLUS4:  pc_next = pc_plus4;
            PC_ALU:    pc_next = {alu_result[`RISKY_XLEN-1:1], 1'b0}; // JALR clears bit 0
            PC_BRANCH: pc_next = taken ? br_target : pc_plus4;
            default:   pc_next = pc;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc <= `RISKY_RESET_PC;
            ir <= '0;
        end else begin
            pc <= pc_next;
            if (uop.ir_load) ir <= mem_rdata;
        end
    end

    always_ff @(posedge clk) begin
        if (uop.addr_load) addr_q <= alu_result;
    end

    // Word access only, low address bits dropped
    assign mem_req.addr  = uop.mem_from_addr ? {addr_q[`RISKY_XLEN-1:2], 2'b00} : pc;
    assign mem_req.wdata = rs2_data;
    assign mem_req.rd_en = uop.mem_rd;
    assign mem_req.wr_en = uop.mem_wr;

    assign opcode = ir.r_fmt.opcode;

    assert property (@(posedge clk) disable iff (!rst_n) pc[1:0] == 2'b00)
        else $error("datapath: PC not word aligned");

endmodule

`default_nettype wire

/* design/risky.sv */
`timescale 1ns/1ps
`default_nettype none

`include "risky_macros.svh"

module risky
    import risky_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic [`RISKY_XLEN-1:0] mem_rdata,
    output mem_req_t               mem_req,
    output logic                   halted
);

    uop_t       uop;
    logic [6:0] opcode;

    risky_ctrl u_ctrl (
        .clk    (clk),
        .rst_n  (rst_n),
        .opcode (opcode),
        .uop    (uop),
        .halted (halted)
    );

    risky_datapath u_datapath (
        .clk       (clk),
        .rst_n     (rst_n),
        .uop       (uop),
        .mem_rdata (mem_rdata),
        .mem_req   (mem_req),
        .opcode    (opcode)
    );

endmodule

`default_nettype wire

/* verif/risky_tests.svh */
// Register and immediate ALU forms on random operands
task automatic alu_ops_test();
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] imm_ext;
    logic [31:0] expect_q[$];
    logic [2:0]  f3;
    logic        alt;
    int          imm_v;
    int          slot;
    int          round;
    for (round = 0; round < 3; round++) begin
        new_program();
        expect_q.delete();
        a = $random(seed);
        b = $random(seed);
        load_const(1, a);
        load_const(2, b);
        for (slot = 0; slot < 10; slot++) begin // SUB and SRA last
            f3  = (slot < 8) ? slot[2:0] : ((slot == 8) ? `RISKY_F3_ADD : `RISKY_F3_SR);
            alt = (slot >= 8);
            emit(r_type(alt ? `RISKY_F7_ALT : 7'd0, 2, 1, f3, 3, `RISKY_OP_OP));
            emit(store_word(3, 0, DATA_BASE + 4 * slot));
            expect_q.push_back(alu_model(f3, alt, a, b));
        end
        for (slot = 10; slot < 19; slot++) begin // SRAI last
            f3  = (slot < 18) ? 3'(slot - 10) : `RISKY_F3_SR;
            alt = (slot == 18);
            if (f3 == `RISKY_F3_SLL || f3 == `RISKY_F3_SR) begin
                imm_v = ($random(seed) & 31) | (alt ? 32'h400 : 0);
            end else begin
                imm_v = $random(seed) & 32'hfff;
            end
            imm_ext = {{20{imm_v[11]}}, imm_v[11:0]};
            emit(i_type(imm_v, 1, f3, 3, `RISKY_OP_OP_IMM));
            emit(store_word(3, 0, DATA_BASE + 4 * slot));
            expect_q.push_back(alu_model(f3, alt, a, imm_ext));
        end
        emit(undefined_op());
        run_program(1000);
        for (slot = 0; slot < 19; slot++) begin
            check_word($sformatf("ALU slot %0d", slot), data_word(slot), expect_q[slot]);
        end
    end
endtask

task automatic upper_imm_test();
    logic [19:0] u_lui;
    logic [19:0] u_auipc;
    int          auipc_pc;
    new_program();
    u_lui   = 20'($random(seed));
    u_auipc = 20'($random(seed));
    emit(u_type(u_lui, 5, `RISKY_OP_LUI));
    auipc_pc = prog_len * 4;
    emit(u_type(u_auipc, 6, `RISKY_OP_AUIPC));
    emit(store_word(5, 0, DATA_BASE));
    emit(store_word(6, 0, DATA_BASE + 4));
    emit(undefined_op());
    run_program(200);
    check_word("LUI value", data_word(0), {u_lui, 12'd0});
    check_word("AUIPC sum", data_word(1), 32'(auipc_pc) + {u_auipc, 12'd0});
endtask

// Each branch jumps over one marker store when taken
task automatic branch_test();
    logic [2:0]  f3_list [6];
    int          rs1_list [3];
    int          rs2_list [3];
    logic [31:0] expect_q[$];
    logic [31:0] a;
    logic [31:0] b;
    int          f;
    int          p;
    int          slot;
    f3_list  = '{`RISKY_F3_BEQ, `RISKY_F3_BNE, `RISKY_F3_BLT,
                 `RISKY_F3_BGE, `RISKY_F3_BLTU, `RISKY_F3_BGEU};
    rs1_list = '{1, 2, 1};
    rs2_list = '{2, 1, 1};
    new_program();
    load_const(1, 32'hffff_fffb); // -5, large when unsigned
    load_const(2, 32'd3);
    emit(i_type(1, 0, `RISKY_F3_ADD, 7, `RISKY_OP_OP_IMM)); // Marker value
    slot = 0;
    for (f = 0; f < 6; f++) begin
        for (p = 0; p < 3; p++) begin
            a = (rs1_list[p] == 1) ? 32'hffff_fffb : 32'd3;
            b = (rs2_list[p] == 1) ? 32'hffff_fffb : 32'd3;
            emit(b_type(8, rs2_list[p], rs1_list[p], f3_list[f]));
            emit(store_word(7, 0, DATA_BASE + 4 * slot));
            expect_q.push_back(branch_model(f3_list[f], a, b) ?
                               fill_word(DATA_BASE + 4 * slot) : 32'd1);
            slot++;
        end
    end
    emit(undefined_op());
    run_program(500);
    for (slot = 0; slot < 18; slot++) begin
        check_word($sformatf("branch slot %0d", slot), data_word(slot), expect_q[slot]);
    end
endtask

task automatic jump_test();
    int jal_pc;
    int jalr_pc;
    new_program();
    emit(i_type('h55, 0, `RISKY_F3_ADD, 9, `RISKY_OP_OP_IMM));
    jal_pc = prog_len * 4;
    emit(j_type(12, 8));
    emit(store_word(9, 0, DATA_BASE + 8)); // Skipped
    emit(store_word(9, 0, DATA_BASE + 8));
    emit(store_word(8, 0, DATA_BASE));
    jalr_pc = prog_len * 4 + 4;
    // Odd base plus offset lands one past the target
    emit(i_type(jalr_pc + 9, 0, `RISKY_F3_ADD, 10, `RISKY_OP_OP_IMM));
    emit(i_type(4, 10, 3'b000, 11, `RISKY_OP_JALR));
    emit(store_word(9, 0, DATA_BASE + 12)); // Skipped
    emit(store_word(9, 0, DATA_BASE + 12));
    emit(store_word(11, 0, DATA_BASE + 4));
    emit(undefined_op());
    run_program(200);
    check_word("JAL link", data_word(0), 32'(jal_pc + 4));
    check_word("JALR link", data_word(1), 32'(jalr_pc + 4));
    check_word("JAL skipped store", data_word(2), fill_word(DATA_BASE + 8));
    check_word("JALR skipped store", data_word(3), fill_word(DATA_BASE + 12));
endtask

task automatic load_store_test();
    logic [31:0] val;
    new_program();
    val = $random(seed);
    load_const(1, val);
    load_const(4, 32'(DATA_BASE));
    emit(store_word(1, 0, DATA_BASE));
    emit(load_word(2, 0, DATA_BASE));
    emit(store_word(2, 0, DATA_BASE + 4));
    emit(load_word(3, 0, DATA_BASE + 2)); // Low address bits ignored
    emit(store_word(3, 0, DATA_BASE + 8));
    emit(i_type(123, 0, `RISKY_F3_ADD, 0, `RISKY_OP_OP_IMM));
    emit(load_word(0, 0, DATA_BASE));
    emit(store_word(0, 0, DATA_BASE + 12));
    emit(load_word(5, 4, 4)); // Base register plus offset
    emit(store_word(5, 4, 16));
    emit(undefined_op());
    run_program(300);
    check_word("SW word", data_word(0), val);
    check_word("LW then SW", data_word(1), val);
    check_word("LW unaligned address", data_word(2), val);
    check_word("x0 after writes", data_word(3), 32'd0);
    check_word("based LW/SW", data_word(4), val);
endtask

task automatic halt_test();
    int writes;
    new_program();
    emit(i_type('h77, 0, `RISKY_F3_ADD, 9, `RISKY_OP_OP_IMM));
    emit(store_word(9, 0, DATA_BASE));
    emit(undefined_op());
    emit(store_word(9, 0, DATA_BASE + 4)); // Never reached
    run_program(200);
    check_halt("halt on undefined opcode", halted, 1'b1);
    writes = write_count;
    repeat (6) @(negedge clk);
    check_halt("halt stays high", halted, 1'b1);
    check_word("writes after halt", write_count, writes);
    check_word("store before halt", data_word(0), 32'h77);
    check_word("store after halt", data_word(1), fill_word(DATA_BASE + 4));
endtask

/* verif/risky_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "risky_macros.svh"

module risky_tb
    import risky_pkg::*;
();

    localparam int DATA_BASE = 'h600; // Data region above the programs

    logic                   clk;
    logic                   rst_n;
    logic [`RISKY_XLEN-1:0] mem_rdata;
    mem_req_t               mem_req;
    logic                   halted;

    logic [`RISKY_XLEN-1:0] mem   [1024];
    logic [`RISKY_XLEN-1:0] image [1024]; // Staged program, copied in during reset
    logic                   image_load;
    int                     write_count;
    int                     prog_len;
    int                     errors;
    int                     bus_errors; // Strobes carrying a misaligned address
    int                     timeouts;
    integer                 seed;

    risky u_risky (
        .clk       (clk),
        .rst_n     (rst_n),
        .mem_rdata (mem_rdata),
        .mem_req   (mem_req),
        .halted    (halted)
    );

    always #10 clk = ~clk;

    // Same-cycle read, bus idles low without a read strobe
    assign mem_rdata = mem_req.rd_en ? mem[mem_req.addr[11:2]] : '0;

    always @(posedge clk) begin
        if (image_load) begin
            for (int i = 0; i < 1024; i++) mem[i] <= image[i];
            write_count <= 0;
        end else if (mem_req.wr_en) begin
            mem[mem_req.addr[11:2]] <= mem_req.wdata;
            write_count <= write_count + 1;
        end
    end

    // Core drives word addresses only
    always @(posedge clk) begin
        if ((mem_req.rd_en || mem_req.wr_en) && mem_req.addr[1:0] != 2'b00) begin
            bus_errors++;
            $display("error: time %0t: bus address %h is not word aligned", $time,
                     mem_req.addr);
        end
    end

    function automatic inst_t r_type(input logic [6:0] f7, input int rs2, input int rs1,
                                     input logic [2:0] f3, input int rd, input logic [6:0] op);
        inst_t w;
        w.r_fmt = '{f7, 5'(rs2), 5'(rs1), f3, 5'(rd), op};
        return w;
    endfunction

    function automatic inst_t i_type(input int imm, input int rs1, input logic [2:0] f3,
                                     input int rd, input logic [6:0] op);
        inst_t w;
        w.i_fmt = '{12'(imm), 5'(rs1), f3, 5'(rd), op};
        return w;
    endfunction

    function automatic inst_t load_word(input int rd, input int rs1, input int imm);
        return i_type(imm, rs1, 3'b010, rd, `RISKY_OP_LOAD); // Word width
    endfunction

    function automatic inst_t store_word(input int rs2, input int rs1, input int imm);
        inst_t       w;
        logic [11:0] i12;
        i12     = 12'(imm);
        w.s_fmt = '{i12[11:5], 5'(rs2), 5'(rs1), 3'b010, i12[4:0], `RISKY_OP_STORE};
        return w;
    endfunction

    // Branch offsets are in bytes, bit 0 dropped
    function automatic inst_t b_type(input int imm, input int rs2, input int rs1,
                                     input logic [2:0] f3);
        inst_t       w;
        logic [12:0] i13;
        i13     = 13'(imm);
        w.s_fmt = '{{i13[12], i13[10:5]}, 5'(rs2), 5'(rs1), f3, {i13[4:1], i13[11]},
                    `RISKY_OP_BRANCH};
        return w;
    endfunction

    function automatic inst_t u_type(input logic [19:0] imm, input int rd,
                                     input logic [6:0] op);
        inst_t w;
        w.u_fmt = '{imm, 5'(rd), op};
        return w;
    endfunction

    function automatic inst_t j_type(input int imm, input int rd);
        inst_t       w;
        logic [20:0] i21;
        i21     = 21'(imm);
        w.u_fmt = '{{i21[20], i21[10:1], i21[11], i21[19:12]}, 5'(rd), `RISKY_OP_JAL};
        return w;
    endfunction

    function automatic inst_t undefined_op();
        inst_t w;
        w.raw = 32'h0000_000b; // custom-0 opcode
        return w;
    endfunction

    // Low two bits zero, so a fetch from here never decodes
    function automatic logic [31:0] fill_word(input int addr);
        return 32'hbad0_0000 | 32'(addr);
    endfunction

    function automatic logic [31:0] data_word(input int k);
        return mem[10'(DATA_BASE / 4 + k)];
    endfunction

    // RV32I base rules
    function automatic logic [31:0] alu_model(input logic [2:0] f3, input logic alt,
                                              input logic [31:0] a, input logic [31:0] b);
        logic [4:0] sh;
        logic       lts;
        sh  = b[4:0];
        lts = (a[31] != b[31]) ? a[31] : (a < b); // Negative side is smaller
        case (f3)
            `RISKY_F3_ADD:  return alt ? a - b : a + b;
            `RISKY_F3_SLL:  return a << sh;
            `RISKY_F3_SLT:  return {31'd0, lts};
            `RISKY_F3_SLTU: return {31'd0, a < b};
            `RISKY_F3_XOR:  return a ^ b;
            `RISKY_F3_SR:   return (a >> sh) | ((alt && a[31]) ? ~(32'hffff_ffff >> sh) : 32'd0);
            `RISKY_F3_OR:   return a | b;
            default:        return a & b;
        endcase
    endfunction

    function automatic logic branch_model(input logic [2:0] f3, input logic [31:0] a,
                                          input logic [31:0] b);
        logic lts;
        lts = (a[31] != b[31]) ? a[31] : (a < b);
        case (f3)
            `RISKY_F3_BEQ:  return a == b;
            `RISKY_F3_BNE:  return a != b;
            `RISKY_F3_BLT:  return lts;
            `RISKY_F3_BGE:  return !lts;
            `RISKY_F3_BLTU: return a < b;
            default:        return a >= b; // BGEU
        endcase
    endfunction

    task automatic new_program();
        for (int i = 0; i < 1024; i++) image[i] = fill_word(4 * i);
        prog_len = 0;
    endtask

    task automatic emit(input inst_t w);
        image[prog_len] = w.raw;
        prog_len++;
    endtask

    task automatic load_const(input int rd, input logic [31:0] val);
        logic [31:0] up;
        up = val + 32'h800; // ADDI sign-extends the low part
        emit(u_type(up[31:12], rd, `RISKY_OP_LUI));
        emit(i_type(int'(val[11:0]), rd, `RISKY_F3_ADD, rd, `RISKY_OP_OP_IMM));
    endtask

    task automatic check_word(input string what, input logic [`RISKY_XLEN-1:0] got,
                              input logic [`RISKY_XLEN-1:0] exp);
        if (got !== exp) begin
            errors++;
            $display("error: time %0t: %s: got %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_halt(input string what, input logic got, input logic exp);
        if (got !== exp) begin
            errors++;
            $display("error: time %0t: %s: halted is %b, expected %b", $time, what, got, exp);
        end
    endtask

    // Reset loads the staged image, then the core runs until it halts
    task automatic run_program(input int limit);
        int cycles;
        @(negedge clk);
        rst_n      = 1'b0;
        image_load = 1'b1;
        @(negedge clk);
        image_load = 1'b0;
        repeat (7) @(negedge clk);
        rst_n  = 1'b1;
        cycles = 0;
        while (!halted && cycles < limit) begin
            @(negedge clk);
            cycles++;
        end
        if (!halted) begin
            timeouts++;
            $display("Timeout: the core did not halt within %0d cycles (time %0t)", limit, $time);
        end
    endtask

    `include "risky_tests.svh"

    initial begin
        clk        = 1'b0;
        rst_n      = 1'b0;
        image_load = 1'b0;
        seed       = 32'hd872;
        errors     = 0;
        timeouts   = 0;
        prog_len   = 0;
        alu_ops_test();
        upper_imm_test();
        branch_test();
        jump_test();
        load_store_test();
        halt_test();
        $display("Checks done: %0d errors, %0d timeouts", errors + bus_errors, timeouts);
        if (errors + bus_errors == 0 && timeouts == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* risky.f */
+incdir+design
+incdir+verif
design/risky_pkg.sv
design/risky_ctrl.sv
design/risky_regfile.sv
design/risky_imm.sv
design/risky_alu.sv
design/risky_datapath.sv
design/risky.sv
verif/risky_tb.sv

/* run.sh */
#!/usr/bin/env bash
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module risky_tb -f risky.f -o risky_sim

./obj_dir/risky_sim | tee sim.log

if grep -q ">>> FAIL" sim.log; then
    echo "Simulation reported failure"
    exit 1
fi

echo "Simulation finished without failure"
